// File: asm_settings.svh
// channel assembler sizing

`ifndef ASM_SETTINGS_SVH
`define ASM_SETTINGS_SVH

// bits per channel word
`define ASM_WIDTH 8

// narrow input channels feeding the assembler
`define ASM_NUM_IN 4

// output lanes making up one wide word
`define ASM_NUM_OUT 4

`endif

// File: asm_data_pkg.sv
// channel assembler data types

`include "asm_settings.svh"

package asm_data_pkg;

   // index widths never drop below one bit
   localparam int IN_IDX_W  = (`ASM_NUM_IN > 1) ? $clog2(`ASM_NUM_IN) : 1;
   localparam int OUT_IDX_W = (`ASM_NUM_OUT > 1) ? $clog2(`ASM_NUM_OUT) : 1;

   // one narrow channel word
   typedef logic [`ASM_WIDTH-1:0] word_t;

   // lane 0 sits in the least significant word
   typedef word_t [`ASM_NUM_OUT-1:0] wide_t;

   // input channel index
   typedef logic [IN_IDX_W-1:0] in_idx_t;

   // output lane index
   typedef logic [OUT_IDX_W-1:0] out_idx_t;

endpackage

// File: asm_ctrl_pkg.sv
// channel assembler control types

package asm_ctrl_pkg;

   // link calibration state
   typedef enum logic
   {
      LINK_DOWN = 1'b0,
      LINK_UP   = 1'b1
   } link_state_e;

endpackage

// File: asm_sel_if.sv
// round-robin selection interface

interface asm_sel_if;

   // channel currently being drained
   asm_data_pkg::in_idx_t  in_ptr;

   // lane receiving the next word
   asm_data_pkg::out_idx_t out_ptr;

   // words may move only while this is high
   logic                   link_up;

   // a word moves from in_ptr to out_ptr this cycle
   logic                   fire;

   modport ctrl
   (
      output in_ptr,
      output out_ptr,
      output link_up,
      input  fire
   );

   modport xbar
   (
      input  in_ptr,
      input  out_ptr,
      input  link_up,
      output fire
   );

endinterface

// File: asm_rr_ctrl.sv
// round-robin control
// link state, pointers and wide-word valid

`include "asm_settings.svh"

module asm_rr_ctrl
(
   input  logic                   clk,
   input  logic                   reset_i,
   input  logic                   calibration_done_i,
   input  asm_data_pkg::in_idx_t  in_top_channel_i,
   input  asm_data_pkg::out_idx_t out_top_channel_i,
   input  logic [`ASM_NUM_OUT-1:0] lane_valid_i,
   output logic                   valid_o,
   asm_sel_if.ctrl                sel
);

   asm_ctrl_pkg::link_state_e state_r;
   asm_ctrl_pkg::link_state_e state_n;
   asm_data_pkg::in_idx_t     in_ptr_r;
   asm_data_pkg::out_idx_t    out_ptr_r;
   logic                      lanes_full;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         asm_ctrl_pkg::LINK_DOWN:
            if (calibration_done_i)
               state_n = asm_ctrl_pkg::LINK_UP;
         asm_ctrl_pkg::LINK_UP:
            if (!calibration_done_i)
               state_n = asm_ctrl_pkg::LINK_DOWN;
         default:
            state_n = asm_ctrl_pkg::LINK_DOWN;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset_i)
         state_r <= asm_ctrl_pkg::LINK_DOWN;
      else
         state_r <= state_n;
   end

   // pointers return to zero whenever the link is or goes down
   always_ff @(posedge clk)
   begin
      if (reset_i || state_n == asm_ctrl_pkg::LINK_DOWN)
      begin
         in_ptr_r  <= '0;
         out_ptr_r <= '0;
      end
      else if (sel.fire)
      begin
         in_ptr_r  <= (in_ptr_r == in_top_channel_i) ? '0 : in_ptr_r + 1'b1;
         out_ptr_r <= (out_ptr_r == out_top_channel_i) ? '0 : out_ptr_r + 1'b1;
      end
   end

   // lanes above the top index do not take part in the wide word
   always_comb
   begin
      lanes_full = 1'b1;
      for (int k = 0; k < `ASM_NUM_OUT; k++)
      begin
         if (k <= int'(out_top_channel_i) && !lane_valid_i[k])
            lanes_full = 1'b0;
      end
   end

   assign valid_o = lanes_full && (state_r == asm_ctrl_pkg::LINK_UP);

   // stop moving words as soon as calibration drops
   assign sel.link_up = (state_r == asm_ctrl_pkg::LINK_UP) && calibration_done_i;
   assign sel.in_ptr  = in_ptr_r;
   assign sel.out_ptr = out_ptr_r;

endmodule

// File: asm_rr_xbar.sv
// channel to lane crossbar

`include "asm_settings.svh"

module asm_rr_xbar
(
   input  logic [`ASM_NUM_IN-1:0]  valid_i,
   input  asm_data_pkg::word_t     data_i [`ASM_NUM_IN],
   output logic [`ASM_NUM_IN-1:0]  yumi_o,
   input  logic [`ASM_NUM_OUT-1:0] enq_ready_i,
   output logic [`ASM_NUM_OUT-1:0] enq_valid_o,
   output asm_data_pkg::word_t     enq_data_o,
   asm_sel_if.xbar                 sel
);

   logic chan_valid;
   logic lane_ready;
   logic fire;

   // the channel under the input pointer
   assign chan_valid = valid_i[sel.in_ptr];

   // the lane under the output pointer
   assign lane_ready = enq_ready_i[sel.out_ptr];

   // a transfer needs a word, room for it and a live link
   assign fire = sel.link_up && chan_valid && lane_ready;

   assign sel.fire = fire;

   // accept goes back only to the selected channel
   always_comb
   begin
      yumi_o = '0;
      for (int i = 0; i < `ASM_NUM_IN; i++)
      begin
         if (i == int'(sel.in_ptr))
            yumi_o[i] = fire;
      end
   end

   // write strobe goes only to the selected lane
   always_comb
   begin
      enq_valid_o = '0;
      for (int k = 0; k < `ASM_NUM_OUT; k++)
      begin
         if (k == int'(sel.out_ptr))
            enq_valid_o[k] = fire;
      end
   end

   // every lane sees the same word, only one of them writes it
   assign enq_data_o = data_i[sel.in_ptr];

endmodule

// File: asm_lane_fifo.sv
// two-entry lane FIFO

module asm_lane_fifo
(
   input  logic                clk,
   input  logic                reset_i,
   input  logic                enq_valid_i,
   output logic                enq_ready_o,
   input  asm_data_pkg::word_t enq_data_i,
   output logic                deq_valid_o,
   output asm_data_pkg::word_t deq_data_o,
   input  logic                deq_yumi_i
);

   asm_data_pkg::word_t mem_r [2];
   logic                head_r;
   logic                tail_r;
   logic [1:0]          count_r;
   logic                enq;
   logic                deq;

   assign enq_ready_o = (count_r != 2'd2);
   assign deq_valid_o = (count_r != 2'd0);
   assign deq_data_o  = mem_r[head_r];

   assign enq = enq_valid_i && enq_ready_o;

   // an acknowledge on an empty lane is ignored
   assign deq = deq_yumi_i && deq_valid_o;

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         head_r  <= 1'b0;
         tail_r  <= 1'b0;
         count_r <= 2'd0;
      end
      else
      begin
         if (enq)
            tail_r <= ~tail_r;
         if (deq)
            head_r <= ~head_r;
         // simultaneous push and pop leaves the count alone
         if (enq && !deq)
            count_r <= count_r + 2'd1;
         else if (deq && !enq)
            count_r <= count_r - 2'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (enq)
         mem_r[tail_r] <= enq_data_i;
   end

endmodule

// File: asm_assembler_in.sv
// channel assembler top level
// round-robin channels into atomic wide words

`include "asm_settings.svh"

module asm_assembler_in
(
   input  logic                    clk,
   input  logic                    reset_i,
   input  logic                    calibration_done_i,
   input  logic [`ASM_NUM_IN-1:0]  valid_i,
   input  asm_data_pkg::word_t     data_i [`ASM_NUM_IN],
   output logic [`ASM_NUM_IN-1:0]  yumi_o,
   input  asm_data_pkg::in_idx_t   in_top_channel_i,
   input  asm_data_pkg::out_idx_t  out_top_channel_i,
   output logic                    valid_o,
   output asm_data_pkg::wide_t     data_o,
   input  logic                    yumi_i
);

   wire [`ASM_NUM_OUT-1:0] enq_valid;
   wire [`ASM_NUM_OUT-1:0] enq_ready;
   wire [`ASM_NUM_OUT-1:0] lane_valid;
   asm_data_pkg::word_t    enq_data;

   asm_sel_if sel ();

   asm_rr_ctrl ctrl0
   (
      .clk                (clk),
      .reset_i            (reset_i),
      .calibration_done_i (calibration_done_i),
      .in_top_channel_i   (in_top_channel_i),
      .out_top_channel_i  (out_top_channel_i),
      .lane_valid_i       (lane_valid),
      .valid_o            (valid_o),
      .sel                (sel.ctrl)
   );

   asm_rr_xbar xbar0
   (
      .valid_i     (valid_i),
      .data_i      (data_i),
      .yumi_o      (yumi_o),
      .enq_ready_i (enq_ready),
      .enq_valid_o (enq_valid),
      .enq_data_o  (enq_data),
      .sel         (sel.xbar)
   );

   // one FIFO per lane, all dequeued together by the wide acknowledge
   for (genvar k = 0; k < `ASM_NUM_OUT; k++)
   begin : g_lane
      asm_lane_fifo lane
      (
         .clk         (clk),
         .reset_i     (reset_i),
         .enq_valid_i (enq_valid[k]),
         .enq_ready_o (enq_ready[k]),
         .enq_data_i  (enq_data),
         .deq_valid_o (lane_valid[k]),
         .deq_data_o  (data_o[k]),
         .deq_yumi_i  (yumi_i)
      );
   end

endmodule

// File: asm_clk_gen.sv
// testbench clock source

module asm_clk_gen
#(
   parameter int PERIOD = 100
)
(
   output logic clk_o
);

   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD / 2) clk_o = ~clk_o;
   end

endmodule

// File: asm_sva.sv
// assembler handshake assertions

`include "asm_settings.svh"

module asm_sva
(
   input logic                   clk,
   input logic                   reset_i,
   input logic [`ASM_NUM_IN-1:0] valid_i,
   input logic [`ASM_NUM_IN-1:0] yumi_o,
   input logic                   valid_o
);

   // only one channel is drained per cycle
   a_yumi_onehot : assert property
   (
      @(posedge clk) disable iff (reset_i)
      $onehot0(yumi_o)
   )
   else
      $error("more than one yumi_o bit high");

   // a channel is only accepted while it offers a word
   a_yumi_valid : assert property
   (
      @(posedge clk) disable iff (reset_i)
      (yumi_o & ~valid_i) == '0
   )
   else
      $error("yumi_o high on a channel without valid_i");

   a_reset_valid : assert property
   (
      @(posedge clk)
      reset_i |=> !valid_o
   )
   else
      $error("valid_o high in the cycle after reset");

endmodule

// File: asm_tb.sv
// channel assembler testbench

`include "asm_settings.svh"

module asm_tb;

   localparam int DRIVE_DLY    = 10;
   localparam int RESET_CYCLES = 10;
   localparam int IDLE_CYCLES  = 20;
   localparam int TEST_TIMEOUT = 4000;

   logic                   clk;
   logic                   reset_i;
   logic                   calibration_done_i;
   logic [`ASM_NUM_IN-1:0] valid_i;
   asm_data_pkg::word_t    data_i [`ASM_NUM_IN];
   logic [`ASM_NUM_IN-1:0] yumi_o;
   asm_data_pkg::in_idx_t  in_top_channel_i;
   asm_data_pkg::out_idx_t out_top_channel_i;
   logic                   valid_o;
   asm_data_pkg::wide_t    data_o;
   logic                   yumi_i;

   int errors;
   int checks;
   int tests;
   int failed;
   bit timed_out;

   // word stream of the current test and its per-channel split
   asm_data_pkg::word_t stream [$];
   asm_data_pkg::word_t chan_q [`ASM_NUM_IN][$];
   asm_data_pkg::wide_t exp_q [$];

   asm_clk_gen #(.PERIOD(100)) clk_gen0 (.clk_o(clk));

   asm_assembler_in dut0
   (
      .clk                (clk),
      .reset_i            (reset_i),
      .calibration_done_i (calibration_done_i),
      .valid_i            (valid_i),
      .data_i             (data_i),
      .yumi_o             (yumi_o),
      .in_top_channel_i   (in_top_channel_i),
      .out_top_channel_i  (out_top_channel_i),
      .valid_o            (valid_o),
      .data_o             (data_o),
      .yumi_i             (yumi_i)
   );

   bind asm_assembler_in asm_sva sva0
   (
      .clk     (clk),
      .reset_i (reset_i),
      .valid_i (valid_i),
      .yumi_o  (yumi_o),
      .valid_o (valid_o)
   );

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("** Error: %s is %h, expected %h", name, actual, expected);
      end
   endtask

   // all channels offer words but the link never comes up
   task automatic link_down_test();
      int start_errors;
      start_errors = errors;
      calibration_done_i = 1'b0;
      for (int i = 0; i < `ASM_NUM_IN; i++)
      begin
         valid_i[i] = 1'b1;
         data_i[i]  = asm_data_pkg::word_t'(i + 1);
      end
      for (int c = 0; c < IDLE_CYCLES; c++)
      begin
         @(negedge clk);
         compare_value("yumi_o", 32'(yumi_o), 32'd0);
         compare_value("valid_o", 32'(valid_o), 32'd0);
         @(posedge clk);
         #DRIVE_DLY;
      end
      valid_i = '0;
      tests++;
      if (errors != start_errors)
         failed++;
      $display("test %-12s %s", "link_down", (errors == start_errors) ? "ok" : "failed");
   endtask

   task automatic play_test(input string name, input int in_top, input int out_top);
      asm_data_pkg::wide_t group;
      asm_data_pkg::wide_t held;
      bit                  held_valid;
      bit                  first_seen;
      bit                  offering [`ASM_NUM_IN];
      int                  start_errors;
      int                  n_groups;
      int                  received;
      int                  cycles;
      start_errors = errors;
      held_valid   = 1'b0;
      first_seen   = 1'b0;
      received     = 0;
      cycles       = 0;
      held         = '0;

      // top indices change only while the link is down
      in_top_channel_i  = asm_data_pkg::in_idx_t'(in_top);
      out_top_channel_i = asm_data_pkg::out_idx_t'(out_top);
      for (int i = 0; i < `ASM_NUM_IN; i++)
      begin
         chan_q[i].delete();
         offering[i] = 1'b0;
      end
      exp_q.delete();
      for (int n = 0; n < stream.size(); n++)
         chan_q[n % (in_top + 1)].push_back(stream[n]);

      // word j of each group belongs in lane j
      n_groups = stream.size() / (out_top + 1);
      for (int g = 0; g < n_groups; g++)
      begin
         group = '0;
         for (int j = 0; j <= out_top; j++)
            group[j] = stream[g * (out_top + 1) + j];
         exp_q.push_back(group);
      end

      calibration_done_i = 1'b1;
      while (exp_q.size() > 0 && !timed_out)
      begin
         // a channel keeps its word up until it is taken
         for (int i = 0; i < `ASM_NUM_IN; i++)
         begin
            if (!offering[i] && chan_q[i].size() > 0 && $urandom_range(3) != 0)
               offering[i] = 1'b1;
            valid_i[i] = offering[i];
            data_i[i]  = offering[i] ? chan_q[i][0] : '0;
         end
         yumi_i = valid_o && ($urandom_range(2) != 0);

         @(negedge clk);
         if (held_valid)
         begin
            compare_value("valid_o while held", 32'(valid_o), 32'd1);
            for (int j = 0; j <= out_top; j++)
               compare_value($sformatf("held data_o[%0d]", j), 32'(data_o[j]), 32'(held[j]));
         end
         for (int i = 0; i < `ASM_NUM_IN; i++)
         begin
            if (yumi_o[i])
            begin
               if (!first_seen)
                  compare_value("first accepted channel", i, 0);
               first_seen = 1'b1;
               if (chan_q[i].size() == 0)
               begin
                  errors++;
                  $display("channel %0d was accepted with no word pending", i);
               end
               else
                  void'(chan_q[i].pop_front());
               offering[i] = 1'b0;
            end
         end
         held_valid = valid_o && !yumi_i;
         held       = data_o;
         if (valid_o && yumi_i)
         begin
            group = exp_q.pop_front();
            for (int j = 0; j <= out_top; j++)
               compare_value($sformatf("data_o[%0d]", j), 32'(data_o[j]), 32'(group[j]));
            received++;
         end

         cycles++;
         if (cycles > TEST_TIMEOUT)
         begin
            errors++;
            timed_out = 1'b1;
            $display("test %s timed out waiting for wide words", name);
         end
         @(posedge clk);
         #DRIVE_DLY;
      end

      valid_i = '0;
      yumi_i  = 1'b0;
      for (int i = 0; i < `ASM_NUM_IN; i++)
         compare_value($sformatf("words left on channel %0d", i), chan_q[i].size(), 0);

      // drop calibration so the pointers clear before the next test
      calibration_done_i = 1'b0;
      repeat (2) @(posedge clk);
      #DRIVE_DLY;

      tests++;
      if (errors != start_errors)
         failed++;
      $display("test %-12s %0d wide words %s", name, received,
               (errors == start_errors) ? "ok" : "failed");
   endtask

   task automatic read_stim_file();
      int                fd;
      int                n;
      int                in_top;
      int                out_top;
      int                count;
      string             tok;
      logic [8*32-1:0]   name_raw;
      logic [8*128-1:0]  line_raw;
      logic [31:0]       word;
      fd = $fopen("asm_stim.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("cannot open the stimulus file asm_stim.txt");
         return;
      end
      while (!timed_out)
      begin
         n = $fscanf(fd, "%s", name_raw);
         if (n != 1)
            break;
         tok = string'(name_raw);
         if (tok[0] == "#")
         begin
            n = $fgets(line_raw, fd);
            continue;
         end
         n = $fscanf(fd, "%d %d %d", in_top, out_top, count);
         if (n != 3)
         begin
            errors++;
            $display("stimulus line for %s is malformed", tok);
            break;
         end
         stream.delete();
         for (int w = 0; w < count; w++)
         begin
            n = $fscanf(fd, "%h", word);
            if (n != 1)
            begin
               errors++;
               $display("stimulus line for %s has too few words", tok);
               break;
            end
            stream.push_back(asm_data_pkg::word_t'(word));
         end
         play_test(tok, in_top, out_top);
      end
      $fclose(fd);
   endtask

   initial
   begin
      void'($urandom(32'h109e));
      errors             = 0;
      checks             = 0;
      tests              = 0;
      failed             = 0;
      timed_out          = 1'b0;
      reset_i            = 1'b1;
      calibration_done_i = 1'b0;
      valid_i            = '0;
      yumi_i             = 1'b0;
      in_top_channel_i   = '0;
      out_top_channel_i  = '0;
      for (int i = 0; i < `ASM_NUM_IN; i++)
         data_i[i] = '0;

      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      reset_i = 1'b0;

      link_down_test();
      read_stim_file();

      $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
      if (errors == 0 && tests > 1)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: asm_stim.txt
# name in_top out_top count then count hex words
# word n goes to channel n mod (in_top+1), lanes take groups of out_top+1
full_4x4 3 3 16 11 22 33 44 55 66 77 88 99 aa bb cc dd ee f0 0f
wrap_2x3 1 2 12 a1 b2 c3 d4 e5 f6 07 18 29 3a 4b 5c
skew_4x3 3 2 9 3c 5a 69 96 a5 c3 0f f0 81
after_drop 3 3 8 de ad be ef ca fe ba be
single_lane 2 0 6 01 80 7f fe 02 40
pair_1x2 0 1 8 10 20 30 40 50 60 70 80
three_3x4 2 3 12 12 34 56 78 9a bc de f0 13 57 9b df
mixed_3x2 2 1 10 21 43 65 87 a9 cb ed 0f 31 53
long_4x4 3 3 24 00 ff 01 fe 02 fd 03 fc 04 fb 05 fa 06 f9 07 f8 08 f7 09 f6 0a f5 0b f4

// File: asm_assembler.f
+incdir+.
asm_data_pkg.sv
asm_ctrl_pkg.sv
asm_sel_if.sv
asm_rr_ctrl.sv
asm_rr_xbar.sv
asm_lane_fifo.sv
asm_assembler_in.sv
asm_clk_gen.sv
asm_sva.sv
asm_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = asm_tb
FILELIST = asm_assembler.f
LOG      = sim.log
PASS_MSG = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
